//--- verilog/disk_io_pkg.sv
// Shared widths, limits, data types and enums for the disk bridge and paddle path
package disk_io_pkg;

	// ====================
	// Sizes and limits
	// ====================

	// Sector buffer
	localparam int BUF_AW         = 9;
	localparam int SECTOR_BYTES   = 512;

	// Host request lines, one per drive slot
	localparam int DRIVE_SLOTS    = 3;

	// Paddle emulation
	localparam int MOUSE_STEP_MAX = 10;
	localparam int AXIS_MIN       = -128;
	localparam int AXIS_MAX       = 127;

	// ====================
	// Data types
	// ====================

	typedef logic [7:0]             byte_t;
	typedef logic [BUF_AW-1:0]      buf_addr_t;
	typedef logic [31:0]            lba_t;
	typedef logic [31:0]            word_t;
	typedef logic [DRIVE_SLOTS-1:0] slot_vec_t;
	typedef logic signed [7:0]      axis_t;

	// Image type reported by the host with a mount
	typedef enum logic [1:0] {
		FT_ATR = 2'd0,
		FT_XEX = 2'd1,
		FT_XFD = 2'd2,
		FT_ATX = 2'd3
	} file_type_e;

	// Phase of an outstanding block request
	typedef enum logic [1:0] {
		IO_IDLE     = 2'd0,
		IO_WAIT_ACK = 2'd1,
		IO_WAIT_END = 2'd2
	} io_state_e;

endpackage

//--- verilog/disk_req_ctrl.sv
// I/O processor strobe decoding, block address register, block request FSM and read mux
`timescale 1ns/1ps
module disk_req_ctrl import disk_io_pkg::*; (
	input  logic       clk_sys,
	input  logic       areset,
	input  logic       lba_sel,
	input  logic       block_rd,
	input  logic       block_wr,
	input  logic [2:0] drv_num,
	input  logic       io_wr,
	input  logic       data_wr,
	input  logic       data_rd,
	input  word_t      wdata,
	input  logic       sd_ack,
	input  byte_t      buf_q,
	input  lba_t       file_size,
	output lba_t       sd_lba,
	output slot_vec_t  sd_rd,
	output slot_vec_t  sd_wr,
	output logic       io_done,
	output logic       buf_we,
	output logic       ptr_step,
	output logic       ptr_clear,
	output word_t      rdata
);
	logic       wr_d1;
	logic       wr_d2;
	logic       rd_d1;
	logic       blrd_d1;
	logic       blwr_d1;
	logic       ack_d1;
	logic       wr_rise;
	logic       blrd_rise;
	logic       blwr_rise;
	logic       ack_fall;
	logic [1:0] slot;
	logic       slot_ok;
	io_state_e  state;

	// ====================
	// Edge detection
	// ====================

	// Data write goes through an extra stage before it counts
	assign wr_rise   = wr_d1 & ~wr_d2;
	assign blrd_rise = block_rd & ~blrd_d1;
	assign blwr_rise = block_wr & ~blwr_d1;
	assign ack_fall  = ack_d1 & ~sd_ack;

	// Drive bits 2 and 0 select the slot, code 3 has no slot behind it
	assign slot    = {drv_num[2], drv_num[0]};
	assign slot_ok = slot < DRIVE_SLOTS;

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			wr_d1   <= 1'b0;
			wr_d2   <= 1'b0;
			rd_d1   <= 1'b0;
			blrd_d1 <= 1'b0;
			blwr_d1 <= 1'b0;
			ack_d1  <= 1'b0;
		end else begin
			wr_d1   <= data_wr;
			wr_d2   <= wr_d1;
			rd_d1   <= data_rd;
			blrd_d1 <= block_rd;
			blwr_d1 <= block_wr;
			ack_d1  <= sd_ack;
		end
	end

	// ====================
	// Data path
	// ====================

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			sd_lba <= '0;
			buf_we <= 1'b0;
		end else begin
			buf_we <= 1'b0;
			if (wr_rise) begin
				if (lba_sel)
					sd_lba <= wdata;
				else
					buf_we <= 1'b1;
			end
		end
	end

	// Read pointer moves once the processor has taken the byte
	assign ptr_step  = rd_d1 & ~data_rd;
	assign ptr_clear = io_wr;
	assign rdata     = lba_sel ? file_size : {24'd0, buf_q};

	// ====================
	// Block requests
	// ====================

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			sd_rd   <= '0;
			sd_wr   <= '0;
			io_done <= 1'b0;
			state   <= IO_IDLE;
		end else begin
			case (state)
				IO_WAIT_ACK: if (sd_ack) state <= IO_WAIT_END;
				IO_WAIT_END: begin
					if (ack_fall) begin
						state   <= IO_IDLE;
						io_done <= 1'b1;
					end
				end
				default: state <= IO_IDLE;
			endcase
			// A new request restarts the wait, extra bits are not queued
			if ((blrd_rise || blwr_rise) && slot_ok) begin
				state   <= IO_WAIT_ACK;
				io_done <= 1'b0;
			end
			if (blrd_rise && slot_ok)
				sd_rd[slot] <= 1'b1;
			if (blwr_rise && slot_ok)
				sd_wr[slot] <= 1'b1;
			// Host acknowledge drops every pending line at once
			if (sd_ack) begin
				sd_rd <= '0;
				sd_wr <= '0;
			end
		end
	end

	a_one_direction: assert property (@(posedge clk_sys) disable iff (areset)
		!((|sd_rd) && (|sd_wr)));

	a_done_after_ack: assert property (@(posedge clk_sys) disable iff (areset)
		(state == IO_WAIT_ACK) |-> !io_done);

endmodule

//--- verilog/sector_buffer.sv
// Dual-port sector RAM with registered reads and the I/O side address pointer
`timescale 1ns/1ps
module sector_buffer import disk_io_pkg::*; (
	input  logic      clk_sys,
	input  logic      areset,
	input  logic      buf_we,
	input  logic      ptr_step,
	input  logic      ptr_clear,
	input  byte_t     wbyte,
	input  buf_addr_t sd_buff_addr,
	input  byte_t     sd_buff_dout,
	input  logic      sd_buff_wr,
	output byte_t     buf_q,
	output byte_t     sd_buff_din
);
	byte_t     mem [SECTOR_BYTES];
	buf_addr_t ptr;

	// ====================
	// I/O side pointer
	// ====================

	// Clear wins over a step in the same cycle
	always_ff @(posedge clk_sys) begin
		if (areset)
			ptr <= '0;
		else if (ptr_clear)
			ptr <= '0;
		else if (buf_we || ptr_step)
			ptr <= ptr + buf_addr_t'(1);
	end

	// ====================
	// RAM
	// ====================

	// Host port and I/O port, the I/O write lands last on a shared address
	always_ff @(posedge clk_sys) begin
		if (sd_buff_wr)
			mem[sd_buff_addr] <= sd_buff_dout;
		if (buf_we)
			mem[ptr] <= wbyte;
		sd_buff_din <= mem[sd_buff_addr];
		buf_q       <= mem[ptr];
	end

	a_we_not_cleared: assert property (@(posedge clk_sys) disable iff (areset)
		!(buf_we && ptr_clear));

endmodule

//--- verilog/mount_tracker.sv
// Image mount latch and I/O processor status byte packing
`timescale 1ns/1ps
module mount_tracker import disk_io_pkg::*; (
	input  logic       clk_sys,
	input  logic       areset,
	input  slot_vec_t  img_mounted,
	input  logic       img_readonly,
	input  lba_t       img_size,
	input  file_type_e img_type,
	input  logic       io_done,
	output byte_t      status,
	output lba_t       file_size
);
	logic       mounted_d1;
	logic       mount_rise;
	logic       mount_tgl;
	logic       read_only;
	logic [2:0] file_no;
	file_type_e file_type;

	assign mount_rise = (|img_mounted) & ~mounted_d1;

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			mounted_d1 <= 1'b0;
			mount_tgl  <= 1'b0;
			read_only  <= 1'b0;
			file_no    <= 3'd0;
			file_type  <= FT_ATR;
			file_size  <= '0;
		end else begin
			mounted_d1 <= |img_mounted;
			if (mount_rise) begin
				// Highest slot wins when several mount together
				if (img_mounted[2])
					file_no <= 3'd4;
				else if (img_mounted[1])
					file_no <= 3'd1;
				else
					file_no <= 3'd0;
				file_type <= img_type;
				// Slot 2 images are never written back
				read_only <= img_readonly | img_mounted[2];
				mount_tgl <= ~mount_tgl;
				file_size <= img_size;
			end
		end
	end

	// Status byte as the I/O processor reads it
	assign status = {read_only, file_type, file_no, mount_tgl, io_done};

endmodule

//--- verilog/mouse_axis.sv
// Mouse to paddle accumulator with step and range clamping and stick source selection
`timescale 1ns/1ps
module mouse_axis import disk_io_pkg::*; (
	input  logic              clk_sys,
	input  logic              areset,
	input  logic signed [8:0] mouse_dx,
	input  logic signed [8:0] mouse_dy,
	input  logic [1:0]        mouse_btn,
	input  logic              mouse_stb,
	input  logic [15:0]       joy_analog,
	input  logic [8:0]        joy_btn,
	input  logic              cpu_halt,
	output axis_t             pad_x,
	output axis_t             pad_y,
	output logic [8:0]        pad_btn
);
	// One bit wider than a pad coordinate
	typedef logic signed [$bits(axis_t):0] pos_t;

	pos_t              pos_x;
	pos_t              pos_y;
	logic signed [9:0] step_x;
	logic signed [9:0] step_y;
	logic signed [9:0] sum_x;
	logic signed [9:0] sum_y;
	logic              stb_d1;
	logic              mouse_mode;
	logic              stick_take;

	function automatic pos_t clamp(input logic signed [9:0] v, input int lo, input int hi);
		if (v < lo)
			return pos_t'(lo);
		if (v > hi)
			return pos_t'(hi);
		return pos_t'(v);
	endfunction

	// ====================
	// Position update
	// ====================

	assign step_x = clamp(mouse_dx, -MOUSE_STEP_MAX, MOUSE_STEP_MAX);
	assign step_y = clamp(mouse_dy, -MOUSE_STEP_MAX, MOUSE_STEP_MAX);
	assign sum_x  = pos_x + step_x;
	assign sum_y  = pos_y + step_y;

	// Any stick deflection or a halted CPU hands the pads back
	assign stick_take = (|joy_analog) | cpu_halt;

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			stb_d1     <= 1'b0;
			mouse_mode <= 1'b0;
			pos_x      <= '0;
			pos_y      <= '0;
		end else begin
			stb_d1 <= mouse_stb;
			if (stick_take) begin
				mouse_mode <= 1'b0;
				pos_x      <= '0;
				pos_y      <= '0;
			end else if (stb_d1 != mouse_stb) begin
				mouse_mode <= 1'b1;
				pos_x      <= clamp(sum_x, AXIS_MIN, AXIS_MAX);
				pos_y      <= clamp(sum_y, AXIS_MIN, AXIS_MAX);
			end
		end
	end

	// Source select
	assign pad_x   = mouse_mode ? axis_t'(pos_x[7:0]) : axis_t'(joy_analog[7:0]);
	assign pad_y   = mouse_mode ? axis_t'(pos_y[7:0]) : axis_t'(joy_analog[15:8]);
	assign pad_btn = {mouse_mode ? mouse_btn : joy_btn[8:7], joy_btn[6:0]};

	a_pos_in_range: assert property (@(posedge clk_sys) disable iff (areset)
		(pos_x >= AXIS_MIN) && (pos_x <= AXIS_MAX) &&
		(pos_y >= AXIS_MIN) && (pos_y <= AXIS_MAX));

endmodule

//--- verilog/disk_io_top.sv
// Top level joining the disk image bridge and the mouse paddle path
`timescale 1ns/1ps
module disk_io_top import disk_io_pkg::*; (
	input  logic              clk_sys,
	input  logic              areset,
	// I/O processor
	input  logic              lba_sel,
	input  logic              block_rd,
	input  logic              block_wr,
	input  logic [2:0]        drv_num,
	input  logic              io_wr,
	input  logic              data_wr,
	input  logic              data_rd,
	input  word_t             wdata,
	output byte_t             status,
	output word_t             rdata,
	// Host image store
	output lba_t              sd_lba,
	output slot_vec_t         sd_rd,
	output slot_vec_t         sd_wr,
	input  logic              sd_ack,
	input  buf_addr_t         sd_buff_addr,
	input  byte_t             sd_buff_dout,
	input  logic              sd_buff_wr,
	output byte_t             sd_buff_din,
	input  slot_vec_t         img_mounted,
	input  logic              img_readonly,
	input  lba_t              img_size,
	input  file_type_e        img_type,
	// Mouse and stick
	input  logic signed [8:0] mouse_dx,
	input  logic signed [8:0] mouse_dy,
	input  logic [1:0]        mouse_btn,
	input  logic              mouse_stb,
	input  logic [15:0]       joy_analog,
	input  logic [8:0]        joy_btn,
	input  logic              cpu_halt,
	output axis_t             pad_x,
	output axis_t             pad_y,
	output logic [8:0]        pad_btn
);
	byte_t buf_q;
	lba_t  file_size;
	logic  io_done;
	logic  buf_we;
	logic  ptr_step;
	logic  ptr_clear;

	// ====================
	// Disk bridge
	// ====================

	disk_req_ctrl ctrl_i (
		.clk_sys, .areset, .lba_sel, .block_rd, .block_wr, .drv_num, .io_wr,
		.data_wr, .data_rd, .wdata, .sd_ack, .buf_q, .file_size, .sd_lba,
		.sd_rd, .sd_wr, .io_done, .buf_we, .ptr_step, .ptr_clear, .rdata
	);

	// Only the low byte of a data write reaches the buffer
	sector_buffer buf_i (
		.clk_sys, .areset, .buf_we, .ptr_step, .ptr_clear, .wbyte(wdata[7:0]),
		.sd_buff_addr, .sd_buff_dout, .sd_buff_wr, .buf_q, .sd_buff_din
	);

	mount_tracker mount_i (
		.clk_sys, .areset, .img_mounted, .img_readonly, .img_size, .img_type,
		.io_done, .status, .file_size
	);

	// ====================
	// Paddle path
	// ====================

	mouse_axis mouse_i (
		.clk_sys, .areset, .mouse_dx, .mouse_dy, .mouse_btn, .mouse_stb,
		.joy_analog, .joy_btn, .cpu_halt, .pad_x, .pad_y, .pad_btn
	);

endmodule

//--- bench/tb_clock.sv
// Testbench clock source with a 4 ns period and a 10 cycle reset
`timescale 1ns/1ps
module tb_clock (
	output logic clk_sys,
	output logic areset
);
	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// Reset drops on a rising edge like any other synchronous input
	initial begin
		areset = 1'b1;
		repeat (10) @(posedge clk_sys);
		areset <= 1'b0;
	end

endmodule

//--- bench/disk_io_tb.sv
// Testbench with random stimulus, reference model, compare tasks and watchdog
`timescale 1ns/1ps
module disk_io_tb import disk_io_pkg::*; ();

	// ====================
	// Test sizes
	// ====================

	localparam int N_REQ          = 8;
	localparam int N_BYTES        = 16;
	localparam int N_MOUNT        = 8;
	localparam int N_MOUSE        = 200;
	localparam int N_TRANS        = 2 * N_REQ + 5 * N_BYTES + N_MOUNT + N_MOUSE;
	localparam int TIMEOUT_CYCLES = N_TRANS * 200;
	localparam int WAIT_LIMIT     = 16;
	localparam int STEP_LIMIT     = 10;
	localparam int POS_LO         = -128;
	localparam int POS_HI         = 127;

	logic              clk_sys;
	logic              areset;
	logic              lba_sel;
	logic              block_rd;
	logic              block_wr;
	logic [2:0]        drv_num;
	logic              io_wr;
	logic              data_wr;
	logic              data_rd;
	word_t             wdata;
	byte_t             status;
	word_t             rdata;
	lba_t              sd_lba;
	slot_vec_t         sd_rd;
	slot_vec_t         sd_wr;
	logic              sd_ack;
	buf_addr_t         sd_buff_addr;
	byte_t             sd_buff_dout;
	logic              sd_buff_wr;
	byte_t             sd_buff_din;
	slot_vec_t         img_mounted;
	logic              img_readonly;
	lba_t              img_size;
	file_type_e        img_type;
	logic signed [8:0] mouse_dx;
	logic signed [8:0] mouse_dy;
	logic [1:0]        mouse_btn;
	logic              mouse_stb;
	logic [15:0]       joy_analog;
	logic [8:0]        joy_btn;
	logic              cpu_halt;
	axis_t             pad_x;
	axis_t             pad_y;
	logic [8:0]        pad_btn;

	integer            seed;
	logic              tgl_model;
	logic              done_model;

	tb_clock clk_i (.clk_sys, .areset);

	disk_io_top dut_i (.*);

	// ====================
	// Reporting
	// ====================

	task automatic end_in_failure();
		$display("Simulation failed");
		$fatal(1, "Run stopped after an error");
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		end_in_failure();
	endtask

	task automatic report_mismatch(input string msg);
		$display("[FAIL] %0t ns: %s", $time, msg);
		end_in_failure();
	endtask

	task automatic check_byte(input byte_t got, input byte_t exp, input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s: got %02h, expected %02h", what, got, exp));
	endtask

	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s: got %08h, expected %08h", what, got, exp));
	endtask

	task automatic check_slots(input slot_vec_t got, input slot_vec_t exp, input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s: got %03b, expected %03b", what, got, exp));
	endtask

	task automatic check_axis(input axis_t got, input axis_t exp, input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s: got %0d, expected %0d", what, got, exp));
	endtask

	function automatic int limit_value(input int v, input int lo, input int hi);
		if (v < lo)
			return lo;
		if (v > hi)
			return hi;
		return v;
	endfunction

	// ====================
	// Bus actions
	// ====================

	// One data_wr pulse, then enough idle cycles for the two stage edge detect
	task automatic io_data_write(input word_t w, input logic sel);
		@(posedge clk_sys);
		lba_sel <= sel;
		wdata   <= w;
		data_wr <= 1'b1;
		@(posedge clk_sys);
		data_wr <= 1'b0;
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic ptr_reset();
		@(posedge clk_sys);
		lba_sel <= 1'b0;
		io_wr   <= 1'b1;
		@(posedge clk_sys);
		io_wr <= 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	// Sample the current byte, then step the pointer and let the RAM catch up
	task automatic io_data_read(output word_t q);
		@(negedge clk_sys);
		q = rdata;
		@(posedge clk_sys);
		data_rd <= 1'b1;
		@(posedge clk_sys);
		data_rd <= 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic host_write(input buf_addr_t a, input byte_t d);
		@(posedge clk_sys);
		sd_buff_addr <= a;
		sd_buff_dout <= d;
		sd_buff_wr   <= 1'b1;
		@(posedge clk_sys);
		sd_buff_wr <= 1'b0;
	endtask

	task automatic host_read(input buf_addr_t a, output byte_t q);
		@(posedge clk_sys);
		sd_buff_addr <= a;
		@(posedge clk_sys);
		@(negedge clk_sys);
		q = sd_buff_din;
	endtask

	task automatic wait_request();
		int n;
		n = 0;
		@(negedge clk_sys);
		while (sd_rd == '0 && sd_wr == '0) begin
			n++;
			if (n > WAIT_LIMIT)
				abort_run("The block request line never rose");
			@(negedge clk_sys);
		end
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		@(negedge clk_sys);
		while (status[0] !== 1'b1) begin
			check_slots(sd_rd | sd_wr, '0, "request lines after acknowledge");
			n++;
			if (n > WAIT_LIMIT)
				abort_run("io_done never rose after the acknowledge fell");
			@(negedge clk_sys);
		end
	endtask

	// ====================
	// Test sequences
	// ====================

	task automatic block_request(input logic is_wr);
		word_t      lba;
		word_t      r;
		logic [1:0] sl;
		slot_vec_t  exp_slots;
		int         delay;
		int         hold;
		lba = $random(seed);
		r   = $random(seed);
		sl  = 2'({$random(seed)} % 3);
		exp_slots = slot_vec_t'(1) << sl;
		io_data_write(lba, 1'b1);
		@(negedge clk_sys);
		check_word(sd_lba, lba, "sd_lba after block address write");
		@(posedge clk_sys);
		drv_num <= {sl[1], r[0], sl[0]};
		if (is_wr)
			block_wr <= 1'b1;
		else
			block_rd <= 1'b1;
		wait_request();
		check_slots(is_wr ? sd_wr : sd_rd, exp_slots, "request slot");
		check_slots(is_wr ? sd_rd : sd_wr, '0, "opposite request lines");
		check_byte({7'd0, status[0]}, 8'd0, "io_done while request pending");
		@(posedge clk_sys);
		block_rd <= 1'b0;
		block_wr <= 1'b0;
		// Host latency varies
		delay = 1 + {$random(seed)} % 8;
		hold  = 1 + {$random(seed)} % 3;
		repeat (delay) @(posedge clk_sys);
		sd_ack <= 1'b1;
		repeat (hold) @(posedge clk_sys);
		@(negedge clk_sys);
		check_slots(sd_rd | sd_wr, '0, "request lines during acknowledge");
		check_byte({7'd0, status[0]}, 8'd0, "io_done during acknowledge");
		@(posedge clk_sys);
		sd_ack <= 1'b0;
		wait_done();
		done_model = 1'b1;
	endtask

	task automatic buffer_round_trip();
		byte_t data [N_BYTES];
		word_t w;
		word_t q;
		byte_t hq;
		int    i;
		ptr_reset();
		for (i = 0; i < N_BYTES; i++) begin
			w = $random(seed);
			data[i] = w[7:0];
			io_data_write(w, 1'b0);
		end
		ptr_reset();
		for (i = 0; i < N_BYTES; i++) begin
			io_data_read(q);
			check_word(q, {24'd0, data[i]}, $sformatf("I/O read of byte %0d", i));
		end
		for (i = 0; i < N_BYTES; i++) begin
			host_read(buf_addr_t'(i), hq);
			check_byte(hq, data[i], $sformatf("host read of byte %0d", i));
		end
	endtask

	task automatic fill_from_host();
		byte_t data [N_BYTES];
		word_t q;
		int    i;
		for (i = 0; i < N_BYTES; i++) begin
			data[i] = byte_t'($random(seed));
			host_write(buf_addr_t'(i), data[i]);
		end
		ptr_reset();
		for (i = 0; i < N_BYTES; i++) begin
			io_data_read(q);
			check_word(q, {24'd0, data[i]}, $sformatf("I/O read of host byte %0d", i));
		end
	endtask

	task automatic mount_image();
		logic [1:0] sl;
		word_t      r;
		lba_t       size;
		file_type_e ft;
		byte_t      exp;
		sl   = 2'({$random(seed)} % 3);
		r    = $random(seed);
		size = $random(seed);
		ft   = file_type_e'(r[2:1]);
		@(posedge clk_sys);
		img_mounted  <= slot_vec_t'(1) << sl;
		img_readonly <= r[0];
		img_type     <= ft;
		img_size     <= size;
		@(posedge clk_sys);
		img_mounted <= '0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		tgl_model = ~tgl_model;
		// Slot 2 maps to file 4 and is always read-only
		exp = {r[0] | (sl == 2'd2), ft, (sl == 2'd2) ? 3'd4 : {1'b0, sl},
			tgl_model, done_model};
		check_byte(status, exp, "status after mount");
		@(posedge clk_sys);
		lba_sel <= 1'b1;
		@(negedge clk_sys);
		check_word(rdata, size, "file size on rdata");
		@(posedge clk_sys);
		lba_sel <= 1'b0;
	endtask

	task automatic paddle_sequence();
		int                px;
		int                py;
		int                i;
		logic              mode;
		logic              bias_x;
		logic              bias_y;
		word_t             r;
		word_t             r2;
		logic [15:0]       ja;
		logic [8:0]        exp_btn;
		logic signed [8:0] dx_v;
		logic signed [8:0] dy_v;
		px     = 0;
		py     = 0;
		mode   = 1'b0;
		bias_x = 1'b0;
		bias_y = 1'b1;
		for (i = 0; i < N_MOUSE; i++) begin
			r  = $random(seed);
			r2 = $random(seed);
			// Long runs in one direction so the position reaches its limits
			if (i % 40 == 39)
				bias_x = ~bias_x;
			if (i % 28 == 27)
				bias_y = ~bias_y;
			dx_v = {bias_x, r2[7:0]};
			dy_v = {bias_y, r2[15:8]};
			@(posedge clk_sys);
			joy_btn   <= r[24:16];
			mouse_btn <= r2[17:16];
			mouse_dx  <= dx_v;
			mouse_dy  <= dy_v;
			if (r[3:0] == 4'd0) begin
				ja = r[4] ? 16'd0 : {r2[31:18], r[5], 1'b1};
				joy_analog <= ja;
				cpu_halt   <= r[4];
				// Report in the same cycle must lose against the stick
				if (r[6])
					mouse_stb <= ~mouse_stb;
				mode = 1'b0;
				px   = 0;
				py   = 0;
			end else begin
				ja = 16'd0;
				joy_analog <= 16'd0;
				cpu_halt   <= 1'b0;
				mouse_stb  <= ~mouse_stb;
				mode = 1'b1;
				px   = limit_value(px + limit_value(dx_v, -STEP_LIMIT, STEP_LIMIT),
					POS_LO, POS_HI);
				py   = limit_value(py + limit_value(dy_v, -STEP_LIMIT, STEP_LIMIT),
					POS_LO, POS_HI);
			end
			@(posedge clk_sys);
			@(negedge clk_sys);
			exp_btn = {mode ? r2[17:16] : r[24:23], r[22:16]};
			check_axis(pad_x, mode ? axis_t'(px) : axis_t'(ja[7:0]), "pad_x");
			check_axis(pad_y, mode ? axis_t'(py) : axis_t'(ja[15:8]), "pad_y");
			check_word(word_t'(pad_btn), word_t'(exp_btn), "pad_btn");
		end
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin
		seed         = 32'hffb;
		tgl_model    = 1'b0;
		done_model   = 1'b0;
		lba_sel      = 1'b0;
		block_rd     = 1'b0;
		block_wr     = 1'b0;
		drv_num      = 3'd0;
		io_wr        = 1'b0;
		data_wr      = 1'b0;
		data_rd      = 1'b0;
		wdata        = '0;
		sd_ack       = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr   = 1'b0;
		img_mounted  = '0;
		img_readonly = 1'b0;
		img_size     = '0;
		img_type     = FT_ATR;
		mouse_dx     = '0;
		mouse_dy     = '0;
		mouse_btn    = '0;
		mouse_stb    = 1'b0;
		joy_analog   = '0;
		joy_btn      = '0;
		cpu_halt     = 1'b0;
		@(negedge areset);
		@(negedge clk_sys);
		check_slots(sd_rd | sd_wr, '0, "request lines after reset");
		check_byte(status, 8'd0, "status after reset");
		check_axis(pad_x, 8'sd0, "pad_x after reset");
		repeat (N_REQ) block_request(1'b0);
		repeat (N_REQ) block_request(1'b1);
		buffer_round_trip();
		fill_from_host();
		repeat (N_MOUNT) mount_image();
		paddle_sequence();
		$display("Simulation completed successfully");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk_sys);
		abort_run($sformatf("The run timed out after %0d cycles", TIMEOUT_CYCLES));
	end

endmodule

//--- build.f
verilog/disk_io_pkg.sv
verilog/disk_req_ctrl.sv
verilog/sector_buffer.sv
verilog/mount_tracker.sv
verilog/mouse_axis.sv
verilog/disk_io_top.sv
bench/tb_clock.sv
bench/disk_io_tb.sv

//--- Bender.yml
package:
  name: disk_io

sources:
  - files:
      - verilog/disk_io_pkg.sv
      - verilog/disk_req_ctrl.sv
      - verilog/sector_buffer.sv
      - verilog/mount_tracker.sv
      - verilog/mouse_axis.sv
      - verilog/disk_io_top.sv
  - target: simulation
    files:
      - bench/tb_clock.sv
      - bench/disk_io_tb.sv
